//--- list.f
source/mrd_pkg.sv
source/mrd_bank_ram.sv
source/mrd_sink.sv
source/mrd_source.sv
source/mrd_ctrl_fsm.sv
source/mrd_buffer_top.sv
testbench/mrd_buffer_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f \
	--top-module mrd_buffer_tb -o sim_mrd_buffer; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_mrd_buffer 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- source/mrd_bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_bank_ram
	import mrd_pkg::*;
(
	input  logic       clk,
	input  logic       wr_en,
	input  bank_addr_t wr_addr,
	input  sample_t    wr_data,
	input  logic       rd_en,
	input  bank_addr_t rd_addr,
	output sample_t    rd_data
);

	sample_t mem [2**ADDR_W];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Holds its value while rd_en is low.
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- source/mrd_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_buffer_top
	import mrd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	output logic       in_ready,
	input  sample_t    in_data,
	input  point_cnt_t frame_len,
	output logic       out_valid,
	input  logic       out_ready,
	output mrd_word_t  out_data,
	output logic       three_quarter,
	output logic       overtime
);

	logic       accept;
	logic       sink_clear;
	logic       sink_done;
	logic       start;
	logic       src_done;
	point_cnt_t word_count;
	mrd_state_t state;
	mrd_wr_t    wr;
	logic       rd_en;
	bank_addr_t rd_addr;
	sample_t    rd_data [N_BANKS];
	mrd_word_t  bank_data;

	mrd_ctrl_fsm mrd_ctrl_fsm_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.frame_len  (frame_len),
		.sink_done  (sink_done),
		.src_done   (src_done),
		.accept     (accept),
		.sink_clear (sink_clear),
		.start      (start),
		.word_count (word_count),
		.overtime   (overtime),
		.state      (state)
	);

	mrd_sink mrd_sink_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.accept        (accept),
		.sink_clear    (sink_clear),
		.in_data       (in_data),
		.frame_len     (frame_len),
		.wr            (wr),
		.sink_done     (sink_done),
		.three_quarter (three_quarter)
	);

	for (genvar i = 0; i < N_BANKS; i++) begin : g_bank
		mrd_bank_ram mrd_bank_ram_i (
			.clk     (clk),
			.wr_en   (wr.wren[i]),
			.wr_addr (wr.wraddr),
			.wr_data (wr.wrdata),
			.rd_en   (rd_en),
			.rd_addr (rd_addr),
			.rd_data (rd_data[i])
		);
	end

	assign bank_data = '{s0: rd_data[0], s1: rd_data[1], s2: rd_data[2], s3: rd_data[3],
		s4: rd_data[4], s5: rd_data[5], s6: rd_data[6]};

	mrd_source mrd_source_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.word_count (word_count),
		.bank_data  (bank_data),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_data   (out_data),
		.src_done   (src_done)
	);

endmodule

`default_nettype wire

//--- source/mrd_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_ctrl_fsm
	import mrd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	output logic       in_ready,
	input  point_cnt_t frame_len,
	input  logic       sink_done,
	input  logic       src_done,
	output logic       accept,
	output logic       sink_clear,
	output logic       start,
	output point_cnt_t word_count,
	output logic       overtime,
	output mrd_state_t state
);

	mrd_state_t state_nxt;
	point_cnt_t ot_cnt;
	logic       wait_cnt;
	logic       ot_hit;

	assign in_ready = (state == IDLE) || (state == SINK);
	assign accept = in_valid && in_ready;

	// The abort cycle clears too, so a dropped frame leaves no bank position behind.
	assign sink_clear = (state == WAIT_WR_END) || (state == SOURCE) || overtime;

	// A frame that completes on the limit cycle is kept.
	assign ot_hit = (state == SINK) && (ot_cnt == OVERTIME_LIMIT) && !sink_done;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (accept)
					state_nxt = SINK;
			end
			SINK: begin
				if (sink_done)
					state_nxt = WAIT_WR_END;
				else if (ot_hit)
					state_nxt = IDLE;
			end
			WAIT_WR_END: begin
				if (wait_cnt) // Last write lands on the second cycle.
					state_nxt = SOURCE;
			end
			SOURCE: begin
				if (src_done)
					state_nxt = IDLE;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			wait_cnt <= 1'b0;
			ot_cnt <= '0;
			overtime <= 1'b0;
			start <= 1'b0;
		end else begin
			state <= state_nxt;
			wait_cnt <= (state == WAIT_WR_END) ? ~wait_cnt : 1'b0;
			ot_cnt <= (state == SINK) ? ot_cnt + 12'd1 : '0;
			overtime <= ot_hit;
			start <= (state == WAIT_WR_END) && wait_cnt; // High in the first Source cycle.
		end
	end

	// Words per frame, taken with the first sample.
	always_ff @(posedge clk) begin
		if ((state == IDLE) && accept)
			word_count <= point_cnt_t'(frame_len / N_BANKS);
	end

endmodule

`default_nettype wire

//--- source/mrd_pkg.sv
`default_nettype none

package mrd_pkg;

	localparam int N_BANKS = 7; // Radix and bank count.
	localparam int ADDR_W = 8; // 256 words per bank.

	typedef logic [31:0] sample_t; // I in [31:16], Q in [15:0].
	typedef logic [11:0] point_cnt_t;
	typedef logic [ADDR_W-1:0] bank_addr_t;
	typedef logic [2:0] bank_sel_t;
	typedef logic [N_BANKS-1:0] wren_t; // One-hot, bit i is bank i.

	// Last sink cycle count before the frame is dropped.
	localparam point_cnt_t OVERTIME_LIMIT = 12'd2047;

	typedef enum logic [1:0] {
		IDLE,
		SINK,
		WAIT_WR_END,
		SOURCE
	} mrd_state_t;

	// One write, broadcast to all banks.
	typedef struct packed {
		bank_addr_t wraddr;
		wren_t      wren;
		sample_t    wrdata;
	} mrd_wr_t;

	// Butterfly input word, field si from bank i.
	typedef struct packed {
		sample_t s0;
		sample_t s1;
		sample_t s2;
		sample_t s3;
		sample_t s4;
		sample_t s5;
		sample_t s6;
	} mrd_word_t;

endpackage

`default_nettype wire

//--- source/mrd_sink.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_sink
	import mrd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       accept,
	input  logic       sink_clear,
	input  sample_t    in_data,
	input  point_cnt_t frame_len,
	output mrd_wr_t    wr,
	output logic       sink_done,
	output logic       three_quarter
);

	bank_sel_t  bank_index;
	bank_sel_t  index_base;
	bank_addr_t bank_addr;
	bank_addr_t addr_base;
	point_cnt_t cnt;
	point_cnt_t cnt_base;
	point_cnt_t cnt_next;
	point_cnt_t three_q_point;
	logic       last_bank;

	logic       vld_s1;
	logic       vld_s2;
	bank_sel_t  index_s1;
	bank_sel_t  index_s2;
	bank_addr_t addr_s1;
	bank_addr_t addr_s2;
	sample_t    data_s1;
	sample_t    data_s2;
	wren_t      wren_dec;

	// A clear together with an accept starts a new frame at this sample.
	assign index_base = sink_clear ? '0 : bank_index;
	assign addr_base = sink_clear ? '0 : bank_addr;
	assign cnt_base = sink_clear ? '0 : cnt;
	assign cnt_next = cnt_base + 12'd1;
	assign last_bank = (index_base == bank_sel_t'(N_BANKS - 1));

	assign three_q_point = (frame_len >> 2) + (frame_len >> 1);
	assign sink_done = accept && (cnt_next == frame_len);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bank_index <= '0;
			bank_addr <= '0;
			cnt <= '0;
			three_quarter <= 1'b0;
		end else begin
			if (accept) begin
				bank_index <= last_bank ? '0 : index_base + 3'd1;
				bank_addr <= last_bank ? addr_base + 1'b1 : addr_base;
				cnt <= cnt_next;
			end else if (sink_clear) begin
				bank_index <= '0;
				bank_addr <= '0;
				cnt <= '0;
			end
			three_quarter <= accept && (cnt_next == three_q_point);
		end
	end

	// Two stages from handshake to bank write.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_s1 <= 1'b0;
			vld_s2 <= 1'b0;
		end else begin
			vld_s1 <= accept;
			vld_s2 <= vld_s1;
		end
	end

	always_ff @(posedge clk) begin
		index_s1 <= index_base;
		addr_s1 <= addr_base;
		data_s1 <= in_data;
		index_s2 <= index_s1;
		addr_s2 <= addr_s1;
		data_s2 <= data_s1;
	end

	assign wren_dec = vld_s2 ? (wren_t'(1) << index_s2) : '0;
	assign wr = '{wraddr: addr_s2, wren: wren_dec, wrdata: data_s2};

endmodule

`default_nettype wire

//--- source/mrd_source.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_source
	import mrd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  point_cnt_t word_count,
	input  mrd_word_t  bank_data,
	output logic       rd_en,
	output bank_addr_t rd_addr,
	output logic       out_valid,
	input  logic       out_ready,
	output mrd_word_t  out_data,
	output logic       src_done
);

	point_cnt_t rd_left; // Words not yet read.
	point_cnt_t sent_cnt;
	logic       handshake;

	assign handshake = out_valid && out_ready;

	// No read while a word is stalled, so the bank registers hold it.
	assign rd_en = (rd_left != '0) && (!out_valid || out_ready);

	assign out_data = bank_data;
	assign src_done = handshake && (sent_cnt == word_count - 12'd1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_left <= '0;
			rd_addr <= '0;
		end else begin
			if (start) begin
				rd_left <= word_count;
				rd_addr <= '0;
			end else if (rd_en) begin
				rd_left <= rd_left - 12'd1;
				rd_addr <= rd_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sent_cnt <= '0;
			out_valid <= 1'b0;
		end else begin
			if (start)
				sent_cnt <= '0;
			else if (handshake)
				sent_cnt <= sent_cnt + 12'd1;

			// Data follows rd_en by one cycle.
			if (rd_en)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- testbench/mrd_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_buffer_tb
	import mrd_pkg::*;
;

	localparam logic [31:0] SEED = 32'd95506;
	localparam int SINK_CYCLE_LIMIT = 2048; // Sink cycles before the frame is dropped.
	localparam int FRAME_SUM = 7 + 21 + 700 + 1792 + 700 + 70;
	localparam int WATCHDOG_CYCLES = FRAME_SUM * 4 + 3000 * 1 + 100;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	logic       in_ready;
	sample_t    in_data;
	point_cnt_t frame_len;
	logic       out_valid;
	logic       out_ready;
	mrd_word_t  out_data;
	logic       three_quarter;
	logic       overtime;

	logic [31:0] data_state = SEED;
	logic [31:0] ready_state = ~SEED; // Second stream for out_ready.

	// Scoreboard state, touched only by the monitor.
	sample_t   grp_q [$];
	mrd_word_t exp_q [$];
	mrd_word_t word_tmp;
	int        acc_cnt;
	int        age;
	logic      active;
	int        words_out = 0;
	int        ot_count = 0;

	// Published expectations.
	logic      exp_avail;
	mrd_word_t exp_head;
	logic      busy; // Frame complete, words still owed.
	logic      busy_prev;
	logic      tq_exp;
	logic      ot_exp;
	logic      stall_prev;
	mrd_word_t held_word;

	mrd_buffer_top mrd_buffer_top_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_data       (in_data),
		.frame_len     (frame_len),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.out_data      (out_data),
		.three_quarter (three_quarter),
		.overtime      (overtime)
	);

	function automatic int next_rand(inout logic [31:0] st);
		st = st * 32'd1664525 + 32'd1013904223;
		return int'({16'd0, st[31:16]}); // Upper bits, the low ones repeat quickly.
	endfunction

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		int r;
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			r = next_rand(ready_state);
			out_ready <= rst_n && (r % 4 != 0);
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES));
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			exp_q.delete();
			grp_q.delete();
			acc_cnt = 0;
			age = 0;
			active = 1'b0;
			exp_avail <= 1'b0;
			exp_head <= '0;
			busy <= 1'b0;
			tq_exp <= 1'b0;
			ot_exp <= 1'b0;
		end else begin
			if (active)
				age = age + 1;
			if (out_valid && out_ready) begin
				words_out = words_out + 1;
				if (exp_q.size() != 0) begin
					void'(exp_q.pop_front());
					if (exp_q.size() == 0)
						busy <= 1'b0;
				end
			end
			if (overtime) begin // Partial frame is dropped.
				grp_q.delete();
				acc_cnt = 0;
				active = 1'b0;
				ot_count = ot_count + 1;
			end
			tq_exp <= 1'b0;
			if (in_valid && in_ready) begin
				if (!active) begin
					active = 1'b1;
					age = 0;
				end
				grp_q.push_back(in_data);
				if (grp_q.size() == 7) begin
					word_tmp = '{s0: grp_q[0], s1: grp_q[1], s2: grp_q[2], s3: grp_q[3],
						s4: grp_q[4], s5: grp_q[5], s6: grp_q[6]};
					exp_q.push_back(word_tmp);
					grp_q.delete();
				end
				acc_cnt = acc_cnt + 1;
				tq_exp <= (acc_cnt == int'(frame_len) / 4 + int'(frame_len) / 2);
				if (acc_cnt == int'(frame_len)) begin
					busy <= 1'b1;
					active = 1'b0;
					acc_cnt = 0;
				end
			end
			ot_exp <= active && (age == SINK_CYCLE_LIMIT);
			exp_avail <= exp_q.size() != 0;
			exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			stall_prev <= 1'b0;
			busy_prev <= 1'b0;
		end else begin
			stall_prev <= out_valid && !out_ready;
			busy_prev <= busy;
		end
		held_word <= out_data;
	end

	a_word_expected: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && out_ready) |-> exp_avail)
		else abort_run($sformatf("output word at %0t with no word expected", $time));

	a_word_data: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && out_ready && exp_avail) |-> (out_data == exp_head))
		else abort_run($sformatf("error %0t out_data got %h expected %h",
			$time, $sampled(out_data), $sampled(exp_head)));

	a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
		stall_prev |-> out_valid)
		else abort_run($sformatf("error %0t out_valid got 0 expected 1", $time));

	a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
		stall_prev |-> (out_data == held_word))
		else abort_run($sformatf("error %0t out_data got %h expected %h",
			$time, $sampled(out_data), $sampled(held_word)));

	a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !in_ready)
		else abort_run($sformatf("error %0t in_ready got 1 expected 0", $time));

	a_ready_back: assert property (@(posedge clk) disable iff (!rst_n)
		(busy_prev && !busy) |-> in_ready)
		else abort_run($sformatf("error %0t in_ready got 0 expected 1", $time));

	a_three_quarter: assert property (@(posedge clk) disable iff (!rst_n)
		three_quarter == tq_exp)
		else abort_run($sformatf("error %0t three_quarter got %b expected %b",
			$time, $sampled(three_quarter), $sampled(tq_exp)));

	a_overtime: assert property (@(posedge clk) disable iff (!rst_n)
		overtime == ot_exp)
		else abort_run($sformatf("error %0t overtime got %b expected %b",
			$time, $sampled(overtime), $sampled(ot_exp)));

	task automatic check_reset_state();
		assert (!out_valid)
			else abort_run($sformatf("error %0t out_valid got 1 expected 0", $time));
		assert (!three_quarter)
			else abort_run($sformatf("error %0t three_quarter got 1 expected 0", $time));
		assert (!overtime)
			else abort_run($sformatf("error %0t overtime got 1 expected 0", $time));
		assert (in_ready)
			else abort_run($sformatf("error %0t in_ready got 0 expected 1", $time));
	endtask

	// A gap_mod of zero sends without gaps.
	task automatic send_samples(input int len, input int count, input int gap_mod);
		int sent;
		int r;
		int r_i;
		int r_q;
		sent = 0;
		@(posedge clk);
		frame_len <= point_cnt_t'(len);
		while (sent < count) begin
			r = next_rand(data_state);
			if (gap_mod != 0 && r % gap_mod == 0) begin
				in_valid <= 1'b0;
			end else begin
				r_i = next_rand(data_state);
				r_q = next_rand(data_state);
				in_valid <= 1'b1;
				in_data <= {r_i[15:0], r_q[15:0]};
			end
			@(posedge clk);
			if (in_valid && in_ready)
				sent = sent + 1;
		end
		in_valid <= 1'b0;
	endtask

	task automatic run_frame(input int n, input int gap_mod);
		int start_words;
		start_words = words_out;
		send_samples(n, n, gap_mod);
		@(posedge clk);
		while (!in_ready) // Back in Idle after the last word.
			@(posedge clk);
		assert (words_out - start_words == n / 7)
			else abort_run($sformatf("frame of %0d samples gave %0d words instead of %0d",
				n, words_out - start_words, n / 7));
	endtask

	task automatic run_aborted_frame(input int len);
		int ot_before;
		int words_before;
		ot_before = ot_count;
		words_before = words_out;
		send_samples(len, 3, 0);
		repeat (2100) @(posedge clk);
		assert (ot_count == ot_before + 1)
			else abort_run($sformatf("overtime pulsed %0d times for the stalled frame",
				ot_count - ot_before));
		assert (words_out == words_before)
			else abort_run("the stalled frame produced output words");
		assert (in_ready)
			else abort_run($sformatf("error %0t in_ready got 0 expected 1", $time));
	endtask

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		frame_len = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_reset_state();

		run_frame(7, 4);
		run_frame(21, 4);
		run_frame(700, 4);
		run_frame(1792, 32); // Sparse gaps keep it under the sink limit.
		run_aborted_frame(700);
		run_frame(70, 4);

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
